//--- design/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // base opcodes of the supported rv32i subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // alu operation select
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    // operand source for the E-stage forwarding muxes
    localparam logic [1:0] FWD_NONE = 2'b00;
    localparam logic [1:0] FWD_W    = 2'b01;
    localparam logic [1:0] FWD_M    = 2'b10;

    // which value goes back to the register file
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    localparam int unsigned DMEM_WORDS = 64;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    // addi x0, x0, 0 is the pipeline bubble
    localparam logic [31:0] NOP_INSTR  = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // one instruction word seen through each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_t;

endpackage

//--- design/hazard_unit.sv
module hazard_unit (
    // decode-stage sources for the load-use check
    input  logic [4:0] rd_addr1_d_i,
    input  logic [4:0] rd_addr2_d_i,
    // execute-stage sources and destination
    input  logic [4:0] rd_addr1_e_i,
    input  logic [4:0] rd_addr2_e_i,
    input  logic [4:0] wr_addr_e_i,
    input  logic       mem_rd_en_e_i,
    // older producers in M and W
    input  logic [4:0] wr_addr_m_i,
    input  logic [4:0] wr_addr_w_i,
    input  logic       reg_wr_en_m_i,
    input  logic       reg_wr_en_w_i,
    // taken branch or jal resolved in E
    input  logic       redirect_e_i,

    output logic [1:0] forward_a_e_o,
    output logic [1:0] forward_b_e_o,
    output logic       stall_o,
    output logic       flush_o
);

    logic m_hits_a;
    logic m_hits_b;
    logic load_use;

    // select for one E operand
    // M is younger than W so it wins when both match
    function automatic logic [1:0] fwd_sel(input logic [4:0] src,
                                           input logic [4:0] dst_m,
                                           input logic       wen_m,
                                           input logic [4:0] dst_w,
                                           input logic       wen_w);
        if (wen_m && (dst_m != 5'd0) && (dst_m == src)) begin
            return rv_pipe_pkg::FWD_M;
        end
        if (wen_w && (dst_w != 5'd0) && (dst_w == src)) begin
            return rv_pipe_pkg::FWD_W;
        end
        return rv_pipe_pkg::FWD_NONE;
    endfunction

    always_comb begin
        forward_a_e_o = fwd_sel(rd_addr1_e_i, wr_addr_m_i, reg_wr_en_m_i,
                                wr_addr_w_i, reg_wr_en_w_i);
        forward_b_e_o = fwd_sel(rd_addr2_e_i, wr_addr_m_i, reg_wr_en_m_i,
                                wr_addr_w_i, reg_wr_en_w_i);
    end

    // loaded value only exists after M, so a direct consumer must wait
    assign m_hits_a = (wr_addr_e_i == rd_addr1_d_i);
    assign m_hits_b = (wr_addr_e_i == rd_addr2_d_i);
    assign load_use = mem_rd_en_e_i && (wr_addr_e_i != 5'd0) && (m_hits_a || m_hits_b);

    assign stall_o = load_use;
    // the core gives the flush priority over the stall
    assign flush_o = redirect_e_i;

endmodule

//--- design/reg_file.sv
module reg_file (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  logic        wr_en_i,
    input  logic [4:0]  wr_addr_i,
    input  logic [31:0] wr_data_i
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 reads zero
    // a write in W shows up on the same-cycle read
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wr_en_i && (wr_addr_i == addr)) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

//--- design/decoder.sv
module decoder (
    input  rv_pipe_pkg::instr_t instr_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    output logic [4:0]  rd_addr_o,
    output logic [31:0] imm_o,
    output logic [2:0]  alu_op_o,
    output logic        alu_src_imm_o,
    output logic        reg_wr_en_o,
    output logic        mem_rd_en_o,
    output logic        mem_wr_en_o,
    output logic        branch_o,
    output logic        jump_o,
    output logic [1:0]  res_src_o
);

    logic       wr_en;
    logic [4:0] rd;

    always_comb begin
        // everything off unless an opcode below claims it
        rs1_addr_o    = '0;
        rs2_addr_o    = '0;
        rd            = '0;
        imm_o         = '0;
        alu_op_o      = rv_pipe_pkg::ALU_ADD;
        alu_src_imm_o = 1'b0;
        wr_en         = 1'b0;
        mem_rd_en_o   = 1'b0;
        mem_wr_en_o   = 1'b0;
        branch_o      = 1'b0;
        jump_o        = 1'b0;
        res_src_o     = rv_pipe_pkg::RES_ALU;

        case (instr_i.r_fmt.opcode)
            rv_pipe_pkg::OPC_OP: begin
                rs1_addr_o = instr_i.r_fmt.rs1;
                rs2_addr_o = instr_i.r_fmt.rs2;
                rd         = instr_i.r_fmt.rd;
                wr_en      = 1'b1;
                case (instr_i.r_fmt.funct3)
                    // funct7 bit 5 tells sub from add
                    3'b000:  alu_op_o = instr_i.r_fmt.funct7[5] ? rv_pipe_pkg::ALU_SUB
                                                                : rv_pipe_pkg::ALU_ADD;
                    3'b010:  alu_op_o = rv_pipe_pkg::ALU_SLT;
                    3'b110:  alu_op_o = rv_pipe_pkg::ALU_OR;
                    3'b111:  alu_op_o = rv_pipe_pkg::ALU_AND;
                    default: wr_en    = 1'b0;
                endcase
            end
            rv_pipe_pkg::OPC_OP_IMM: begin
                // addi only
                rs1_addr_o    = instr_i.i_fmt.rs1;
                rd            = instr_i.i_fmt.rd;
                imm_o         = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
                alu_src_imm_o = 1'b1;
                wr_en         = (instr_i.i_fmt.funct3 == 3'b000);
            end
            rv_pipe_pkg::OPC_LOAD: begin
                rs1_addr_o    = instr_i.i_fmt.rs1;
                rd            = instr_i.i_fmt.rd;
                imm_o         = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
                alu_src_imm_o = 1'b1;
                wr_en         = (instr_i.i_fmt.funct3 == 3'b010);
                mem_rd_en_o   = wr_en;
                res_src_o     = rv_pipe_pkg::RES_MEM;
            end
            rv_pipe_pkg::OPC_STORE: begin
                rs1_addr_o    = instr_i.s_fmt.rs1;
                rs2_addr_o    = instr_i.s_fmt.rs2;
                imm_o         = {{20{instr_i.s_fmt.imm_hi[6]}},
                                 instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
                alu_src_imm_o = 1'b1;
                mem_wr_en_o   = (instr_i.s_fmt.funct3 == 3'b010);
            end
            rv_pipe_pkg::OPC_BRANCH: begin
                // beq compares by subtraction
                rs1_addr_o = instr_i.b_fmt.rs1;
                rs2_addr_o = instr_i.b_fmt.rs2;
                imm_o      = {{20{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_11,
                              instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
                alu_op_o   = rv_pipe_pkg::ALU_SUB;
                branch_o   = (instr_i.b_fmt.funct3 == 3'b000);
            end
            rv_pipe_pkg::OPC_JAL: begin
                // j immediate taken from the raw r view bit fields
                rd        = instr_i.r_fmt.rd;
                imm_o     = {{12{instr_i.r_fmt.funct7[6]}}, instr_i.r_fmt.rs1,
                             instr_i.r_fmt.funct3, instr_i.r_fmt.rs2[0],
                             instr_i.r_fmt.funct7[5:0], instr_i.r_fmt.rs2[4:1], 1'b0};
                wr_en     = 1'b1;
                jump_o    = 1'b1;
                res_src_o = rv_pipe_pkg::RES_PC4;
            end
            default: ;
        endcase
    end

    // writes to x0 are dropped here and never reach writeback
    assign rd_addr_o   = rd;
    assign reg_wr_en_o = wr_en && (rd != 5'd0);

endmodule

//--- design/alu.sv
module alu (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic [2:0]  op_i,
    output logic [31:0] result_o,
    output logic        zero_o
);

    always_comb begin
        case (op_i)
            rv_pipe_pkg::ALU_SUB: result_o = a_i - b_i;
            rv_pipe_pkg::ALU_AND: result_o = a_i & b_i;
            rv_pipe_pkg::ALU_OR:  result_o = a_i | b_i;
            // signed compare
            rv_pipe_pkg::ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            default:              result_o = a_i + b_i;
        endcase
    end

    // equal operands for beq
    assign zero_o = (a_i == b_i);

endmodule

//--- design/data_mem.sv
module data_mem (
    input  logic        clk_i,
    input  logic        wr_en_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wr_data_i,
    output logic [31:0] rd_data_o
);

    logic [31:0] mem [rv_pipe_pkg::DMEM_WORDS];
    logic [5:0]  word_idx;

    // word index only, byte offset ignored
    assign word_idx = addr_i[7:2];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[word_idx] <= wr_data_i;
        end
    end

    // read is combinational so lw data is ready in M
    assign rd_data_o = mem[word_idx];

    // only whole words are stored
    a_word_aligned: assert property (@(posedge clk_i) wr_en_i |-> (addr_i[1:0] == 2'b00))
        else $error("misaligned store to %h", addr_i);

endmodule

//--- design/rv_pipe_core.sv
module rv_pipe_core (
    input  logic        clk_i,
    input  logic        reset_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] instr_i,
    output logic        wb_en_o,
    output logic [4:0]  wb_addr_o,
    output logic [31:0] wb_data_o
);

    logic [31:0] pc_q;
    rv_pipe_pkg::instr_t instr_d_q;
    logic [31:0] pc_d_q;
    logic [4:0]  rs1_addr_d, rs2_addr_d, rd_addr_d;
    logic [31:0] imm_d, rs1_data_d, rs2_data_d;
    logic [2:0]  alu_op_d;
    logic [1:0]  res_src_d;
    logic        alu_src_imm_d, reg_wr_en_d, mem_rd_en_d, mem_wr_en_d, branch_d, jump_d;
    logic        reg_wr_en_e, mem_rd_en_e, mem_wr_en_e, branch_e, jump_e, alu_src_imm_e;
    logic [4:0]  rs1_addr_e, rs2_addr_e, rd_addr_e;
    logic [31:0] rs1_data_e, rs2_data_e, imm_e, pc_e;
    logic [2:0]  alu_op_e;
    logic [1:0]  res_src_e, fwd_a_e, fwd_b_e;
    logic [31:0] src_a_e, src_b_e, alu_result_e, target_e;
    logic        zero_e, redirect_e, stall, flush;
    logic        reg_wr_en_m, mem_wr_en_m;
    logic [4:0]  rd_addr_m;
    logic [1:0]  res_src_m;
    logic [31:0] alu_result_m, store_data_m, pc4_m, fwd_m_val, mem_rd_data_m;
    logic        reg_wr_en_w;
    logic [4:0]  rd_addr_w;
    logic [1:0]  res_src_w;
    logic [31:0] alu_result_w, mem_data_w, pc4_w, result_w;

    // fetch
    // flush beats stall so a redirect is never lost
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= rv_pipe_pkg::RESET_PC;
        end else if (flush) begin
            pc_q <= target_e;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end
    assign imem_addr_o = pc_q;

    // IF/ID holds on a stall and takes a bubble on a flush
    always_ff @(posedge clk_i) begin
        if (reset_i || flush) begin
            instr_d_q <= rv_pipe_pkg::NOP_INSTR;
        end else if (!stall) begin
            instr_d_q <= instr_i;
        end
    end
    always_ff @(posedge clk_i) begin
        if (!stall) begin
            pc_d_q <= pc_q;
        end
    end

    decoder u_decoder (
        .instr_i(instr_d_q), .rs1_addr_o(rs1_addr_d), .rs2_addr_o(rs2_addr_d),
        .rd_addr_o(rd_addr_d), .imm_o(imm_d), .alu_op_o(alu_op_d),
        .alu_src_imm_o(alu_src_imm_d), .reg_wr_en_o(reg_wr_en_d), .mem_rd_en_o(mem_rd_en_d),
        .mem_wr_en_o(mem_wr_en_d), .branch_o(branch_d), .jump_o(jump_d), .res_src_o(res_src_d)
    );

    // written from W, read in D
    reg_file u_reg_file (
        .clk_i(clk_i), .reset_i(reset_i), .rs1_addr_i(rs1_addr_d), .rs2_addr_i(rs2_addr_d),
        .rs1_data_o(rs1_data_d), .rs2_data_o(rs2_data_d), .wr_en_i(reg_wr_en_w),
        .wr_addr_i(rd_addr_w), .wr_data_i(result_w)
    );

    hazard_unit u_hazard_unit (
        .rd_addr1_d_i(rs1_addr_d), .rd_addr2_d_i(rs2_addr_d), .rd_addr1_e_i(rs1_addr_e),
        .rd_addr2_e_i(rs2_addr_e), .wr_addr_e_i(rd_addr_e), .mem_rd_en_e_i(mem_rd_en_e),
        .wr_addr_m_i(rd_addr_m), .wr_addr_w_i(rd_addr_w), .reg_wr_en_m_i(reg_wr_en_m),
        .reg_wr_en_w_i(reg_wr_en_w), .redirect_e_i(redirect_e), .forward_a_e_o(fwd_a_e),
        .forward_b_e_o(fwd_b_e), .stall_o(stall), .flush_o(flush)
    );

    // ID/EX control flags cleared for a bubble
    always_ff @(posedge clk_i) begin
        if (reset_i || flush || stall) begin
            {reg_wr_en_e, mem_rd_en_e, mem_wr_en_e, branch_e, jump_e} <= '0;
        end else begin
            {reg_wr_en_e, mem_rd_en_e, mem_wr_en_e, branch_e, jump_e} <=
                {reg_wr_en_d, mem_rd_en_d, mem_wr_en_d, branch_d, jump_d};
        end
    end
    always_ff @(posedge clk_i) begin
        {rs1_addr_e, rs2_addr_e, rd_addr_e} <= {rs1_addr_d, rs2_addr_d, rd_addr_d};
        {rs1_data_e, rs2_data_e, imm_e, pc_e} <= {rs1_data_d, rs2_data_d, imm_d, pc_d_q};
        {alu_op_e, alu_src_imm_e, res_src_e} <= {alu_op_d, alu_src_imm_d, res_src_d};
    end

    // operand mux shared by both E sources
    function automatic logic [31:0] fwd_mux(input logic [1:0]  sel,
                                            input logic [31:0] reg_val,
                                            input logic [31:0] m_val,
                                            input logic [31:0] w_val);
        case (sel)
            rv_pipe_pkg::FWD_M: return m_val;
            rv_pipe_pkg::FWD_W: return w_val;
            default:            return reg_val;
        endcase
    endfunction

    // a jal in M forwards its link value, not the alu result
    assign fwd_m_val = (res_src_m == rv_pipe_pkg::RES_PC4) ? pc4_m : alu_result_m;
    assign src_a_e   = fwd_mux(fwd_a_e, rs1_data_e, fwd_m_val, result_w);
    assign src_b_e   = fwd_mux(fwd_b_e, rs2_data_e, fwd_m_val, result_w);

    alu u_alu (
        .a_i(src_a_e), .b_i(alu_src_imm_e ? imm_e : src_b_e), .op_i(alu_op_e),
        .result_o(alu_result_e), .zero_o(zero_e)
    );

    // beq and jal are both pc relative
    assign target_e   = pc_e + imm_e;
    assign redirect_e = jump_e || (branch_e && zero_e);

    // EX/MEM
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {reg_wr_en_m, mem_wr_en_m} <= '0;
        end else begin
            {reg_wr_en_m, mem_wr_en_m} <= {reg_wr_en_e, mem_wr_en_e};
        end
    end
    always_ff @(posedge clk_i) begin
        {rd_addr_m, res_src_m} <= {rd_addr_e, res_src_e};
        {alu_result_m, store_data_m, pc4_m} <= {alu_result_e, src_b_e, pc_e + 32'd4};
    end

    data_mem u_data_mem (
        .clk_i(clk_i), .wr_en_i(mem_wr_en_m), .addr_i(alu_result_m),
        .wr_data_i(store_data_m), .rd_data_o(mem_rd_data_m)
    );

    // MEM/WB
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reg_wr_en_w <= 1'b0;
        end else begin
            reg_wr_en_w <= reg_wr_en_m;
        end
    end
    always_ff @(posedge clk_i) begin
        {rd_addr_w, res_src_w} <= {rd_addr_m, res_src_m};
        {alu_result_w, mem_data_w, pc4_w} <= {alu_result_m, mem_rd_data_m, pc4_m};
    end

    always_comb begin
        case (res_src_w)
            rv_pipe_pkg::RES_MEM: result_w = mem_data_w;
            rv_pipe_pkg::RES_PC4: result_w = pc4_w;
            default:              result_w = alu_result_w;
        endcase
    end

    assign wb_en_o   = reg_wr_en_w;
    assign wb_addr_o = rd_addr_w;
    assign wb_data_o = result_w;

    // the two slots behind a redirect reach E as bubbles
    a_flush_two_bubbles: assert property (@(posedge clk_i) disable iff (reset_i)
        flush |=> !flush ##1 !flush);
    // the load-use bubble lasts exactly one cycle
    a_stall_once: assert property (@(posedge clk_i) disable iff (reset_i)
        (stall && !flush) |=> !stall);

endmodule

//--- verification/tb_rv_pipe_core.sv
module tb_rv_pipe_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int PROG_LEN     = 23;
    localparam int WAIT_CYCLES  = 300;
    // last data word, well inside the 12-bit offset range
    localparam logic [11:0] DMEM_TOP = 12'((rv_pipe_pkg::DMEM_WORDS - 1) * 4);

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] instr;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] rom [PROG_LEN];
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    int          neg_cnt = 0;
    int          wb_idx = 0;

    rv_pipe_core UUT (
        .clk_i(clk),
        .reset_i(reset),
        .imem_addr_o(imem_addr),
        .instr_i(instr),
        .wb_en_o(wb_en),
        .wb_addr_o(wb_addr),
        .wb_data_o(wb_data)
    );

    // same-cycle fetch, nop past the end of the program
    assign instr = (imem_addr < 32'(PROG_LEN * 4)) ? rom[imem_addr[6:2]]
                                                   : rv_pipe_pkg::NOP_INSTR;

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        rv_pipe_pkg::instr_t w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = rv_pipe_pkg::OPC_OP;
        return w;
    endfunction

    // addi and lw share the i format
    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        rv_pipe_pkg::instr_t w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        rv_pipe_pkg::instr_t w;
        w.s_fmt.imm_hi = imm[11:5];
        w.s_fmt.rs2    = rs2;
        w.s_fmt.rs1    = rs1;
        w.s_fmt.funct3 = 3'b010;
        w.s_fmt.imm_lo = imm[4:0];
        w.s_fmt.opcode = rv_pipe_pkg::OPC_STORE;
        return w;
    endfunction

    // byte offset, bit 0 is implied zero
    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        rv_pipe_pkg::instr_t w;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.rs2      = rs2;
        w.b_fmt.rs1      = rs1;
        w.b_fmt.funct3   = 3'b000;
        w.b_fmt.imm_4_1  = off[4:1];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.opcode   = rv_pipe_pkg::OPC_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pipe_pkg::OPC_JAL};
    endfunction

    task automatic add_expected(input logic [4:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic value_error(input string sig, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        $display("Error %s expected %h actual %h", sig, exp_val, act_val);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    initial begin
        // dependent chain, M then W forwarding
        rom[0]  = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5);
        rom[1]  = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd1, 12'd3);
        rom[2]  = r_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        rom[3]  = r_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
        rom[4]  = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd0, 12'hffe);
        // x0 write must vanish, reader of x0 at distance one
        rom[5]  = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd9);
        rom[6]  = r_word(7'h00, 3'b000, 5'd6, 5'd0, 5'd5);
        // x5 at distance three goes through the register file
        rom[7]  = r_word(7'h00, 3'b010, 5'd7, 5'd5, 5'd1);
        rom[8]  = r_word(7'h00, 3'b111, 5'd8, 5'd3, 5'd2);
        rom[9]  = r_word(7'h00, 3'b110, 5'd9, 5'd3, 5'd5);
        // store, load, then a direct use of the load
        rom[10] = sw_word(5'd3, 5'd0, DMEM_TOP);
        rom[11] = i_word(rv_pipe_pkg::OPC_LOAD, 3'b010, 5'd10, 5'd0, DMEM_TOP);
        rom[12] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd11, 5'd10, 12'd1);
        // 5 != 8 so nothing is flushed
        rom[13] = beq_word(5'd1, 5'd2, 13'd8);
        rom[14] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd12, 5'd0, 12'd7);
        // taken, pc 60 to 72
        rom[15] = beq_word(5'd12, 5'd12, 13'd12);
        rom[16] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 12'd1);
        rom[17] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd14, 5'd0, 12'd2);
        // pc 72 to 84, link 76
        rom[18] = jal_word(5'd15, 21'd12);
        rom[19] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 12'd3);
        rom[20] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd14, 5'd0, 12'd4);
        rom[21] = r_word(7'h00, 3'b000, 5'd16, 5'd15, 5'd11);
        // sentinel
        rom[22] = i_word(rv_pipe_pkg::OPC_OP_IMM, 3'b000, 5'd31, 5'd0, 12'h055);

        add_expected(5'd1, 32'h0000_0005);
        add_expected(5'd2, 32'h0000_0008);
        add_expected(5'd3, 32'h0000_000d);
        // 13 - 5
        add_expected(5'd4, 32'h0000_0008);
        add_expected(5'd5, 32'hffff_fffe);
        add_expected(5'd6, 32'hffff_fffe);
        // signed, -2 < 5
        add_expected(5'd7, 32'h0000_0001);
        add_expected(5'd8, 32'h0000_0008);
        add_expected(5'd9, 32'hffff_ffff);
        add_expected(5'd10, 32'h0000_000d);
        add_expected(5'd11, 32'h0000_000e);
        add_expected(5'd12, 32'h0000_0007);
        // x13 and x14 are flushed both times
        add_expected(5'd15, 32'h0000_004c);
        // 76 + 14
        add_expected(5'd16, 32'h0000_005a);
        add_expected(5'd31, 32'h0000_0055);
    end

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // outputs checked on the falling edge, half a cycle after they change
    always @(negedge clk) begin
        neg_cnt++;
        if (neg_cnt <= RESET_CYCLES) begin
            // reset and the cycle it is released in
            assert (imem_addr == rv_pipe_pkg::RESET_PC)
                else value_error("imem_addr_o", rv_pipe_pkg::RESET_PC, imem_addr);
            assert (!wb_en)
                else value_error("wb_en_o", 32'd0, 32'(wb_en));
        end
        if (wb_en) begin
            assert (wb_idx < exp_addr.size())
                else plain_error("register write seen after the last expected one");
            assert (wb_addr != 5'd0)
                else plain_error("write to x0 appeared on the writeback ports");
            assert (wb_addr == exp_addr[wb_idx])
                else value_error("wb_addr_o", 32'(exp_addr[wb_idx]), 32'(wb_addr));
            assert (wb_data == exp_data[wb_idx])
                else value_error("wb_data_o", exp_data[wb_idx], wb_data);
            wb_idx++;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int cyc = 0; cyc < WAIT_CYCLES; cyc++) begin
            @(posedge clk);
            if (wb_idx == exp_addr.size()) begin
                break;
            end
        end
        // let trailing nops run so a stray write would still be caught
        repeat (8) @(posedge clk);

        if (wb_idx != exp_addr.size()) begin
            plain_error("timeout waiting for the sentinel write");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- rv_pipe_core.f
design/rv_pipe_pkg.sv
design/hazard_unit.sv
design/reg_file.sv
design/decoder.sv
design/alu.sv
design/data_mem.sv
design/rv_pipe_core.sv
verification/tb_rv_pipe_core.sv

//--- Makefile
TOP := tb_rv_pipe_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f rv_pipe_core.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
